// ==== files.f ====
logic/qrPkg.sv
logic/cordicMicroStep.sv
logic/rotationFinish.sv
logic/givensStage.sv
logic/qrDecomp4.sv
tb/qrDecomp_checker.sv
tb/qrDecompTb.sv

// ==== logic/cordicMicroStep.sv ====
`timescale 1ns/1ps

module cordicMicroStep #(
    parameter int stepIndex = 0,
    parameter int pivotLane = 0
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           inVal,
    input  qrPkg::rotLanes inLanes,
    output logic           outVal,
    output qrPkg::rotLanes outLanes
);
    import qrPkg::*;

    rotDir   dir;
    rotLanes rotated;

    // the pivot lane alone decides where all eight lanes turn
    assign dir = inLanes.y[pivotLane][dataWidth-1] ? rotUp : rotDown;

    always_comb begin
        fixVal xIn;
        fixVal yIn;
        fixVal xSh;
        fixVal ySh;
        rotated = inLanes;  // bypass flag rides along
        for (int i = 0; i < laneCount; i++) begin
            xIn = inLanes.x[i];
            yIn = inLanes.y[i];
            xSh = xIn >>> stepIndex;  // arithmetic, rounds toward minus infinity
            ySh = yIn >>> stepIndex;
            if (!inLanes.bypass) begin
                if (dir == rotDown) begin
                    rotated.x[i] = xIn + ySh;
                    rotated.y[i] = yIn - xSh;
                end else begin
                    rotated.x[i] = xIn - ySh;
                    rotated.y[i] = yIn + xSh;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            outVal <= 1'b0;
        end else begin
            outVal <= inVal;
        end
    end

    always_ff @(posedge clk) begin
        outLanes <= rotated;
    end

endmodule

// ==== logic/givensStage.sv ====
`timescale 1ns/1ps

module givensStage #(
    parameter int rowI        = 0,
    parameter int rowJ        = 1,
    parameter int pivotCol    = 0,
    parameter int cordicSteps = 16
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          inVal,
    input  qrPkg::qrState inState,
    output logic          outVal,
    output qrPkg::qrState outState
);
    import qrPkg::*;

    localparam int delayLen = cordicSteps + 2;  // pre-rotation + steps + finish

    rotLanes gathered;
    rotLanes preLanes;
    logic    preVal;
    rotLanes chainLanes [cordicSteps+1];
    logic    chainVal [cordicSteps+1];
    rotLanes finLanes;
    qrState  delayLine [delayLen];

    // pick the two rows out of R and qt, flip by 180 degrees when the pivot x is negative
    always_comb begin
        logic flip;
        fixVal xv;
        fixVal yv;
        flip = inState.r.el[rowI][pivotCol][dataWidth-1];
        for (int c = 0; c < 4; c++) begin
            xv = inState.r.el[rowI][c];
            yv = inState.r.el[rowJ][c];
            gathered.x[c] = flip ? -xv : xv;
            gathered.y[c] = flip ? -yv : yv;
            xv = inState.qt.el[rowI][c];
            yv = inState.qt.el[rowJ][c];
            gathered.x[c+4] = flip ? -xv : xv;
            gathered.y[c+4] = flip ? -yv : yv;
        end
        gathered.bypass = (inState.r.el[rowJ][pivotCol] == '0);  // nothing to eliminate
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            preVal <= 1'b0;
        end else begin
            preVal <= inVal;
        end
    end

    always_ff @(posedge clk) begin
        preLanes <= gathered;
    end

    assign chainLanes[0] = preLanes;
    assign chainVal[0]   = preVal;

    for (genvar k = 0; k < cordicSteps; k++) begin : gSteps
        cordicMicroStep #(
            .stepIndex (k),
            .pivotLane (pivotCol)
        ) uStep (
            .clk      (clk),
            .reset    (reset),
            .inVal    (chainVal[k]),
            .inLanes  (chainLanes[k]),
            .outVal   (chainVal[k+1]),
            .outLanes (chainLanes[k+1])
        );
    end

    rotationFinish #(
        .cordicSteps (cordicSteps),
        .pivotLane   (pivotCol)
    ) uFinish (
        .clk      (clk),
        .reset    (reset),
        .inVal    (chainVal[cordicSteps]),
        .inLanes  (chainLanes[cordicSteps]),
        .outVal   (outVal),
        .outLanes (finLanes)
    );

    // the other rows wait beside the rotation
    always_ff @(posedge clk) begin
        delayLine[0] <= inState;
        for (int i = 1; i < delayLen; i++) begin
            delayLine[i] <= delayLine[i-1];
        end
    end

    always_comb begin
        outState = delayLine[delayLen-1];
        for (int c = 0; c < 4; c++) begin
            outState.r.el[rowI][c]  = finLanes.x[c];
            outState.r.el[rowJ][c]  = finLanes.y[c];
            outState.qt.el[rowI][c] = finLanes.x[c+4];
            outState.qt.el[rowJ][c] = finLanes.y[c+4];
        end
    end

endmodule

// ==== logic/qrDecomp4.sv ====
`timescale 1ns/1ps

module qrDecomp4 #(
    parameter int cordicSteps = 16
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          inVal,
    input  qrPkg::matrix4 inMatrix,
    output logic          outVal,
    output qrPkg::matrix4 rMatrix,
    output qrPkg::matrix4 qMatrix
);
    import qrPkg::*;

    // elimination order: column 0 below row 0, then column 1, then column 2
    localparam int rowITab [6]  = '{0, 0, 0, 1, 1, 2};
    localparam int rowJTab [6]  = '{1, 2, 3, 2, 3, 3};
    localparam int pivotTab [6] = '{0, 0, 0, 1, 1, 2};

    qrState loadState;
    logic   loadVal;
    qrState stageState [7];
    logic   stageVal [7];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loadVal <= 1'b0;
        end else begin
            loadVal <= inVal;
        end
    end

    always_ff @(posedge clk) begin
        loadState.r <= inMatrix;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                loadState.qt.el[r][c] <= (r == c) ? fixOne : '0;  // identity
            end
        end
    end

    assign stageState[0] = loadState;
    assign stageVal[0]   = loadVal;

    for (genvar s = 0; s < 6; s++) begin : gRot
        givensStage #(
            .rowI        (rowITab[s]),
            .rowJ        (rowJTab[s]),
            .pivotCol    (pivotTab[s]),
            .cordicSteps (cordicSteps)
        ) uStage (
            .clk      (clk),
            .reset    (reset),
            .inVal    (stageVal[s]),
            .inState  (stageState[s]),
            .outVal   (stageVal[s+1]),
            .outState (stageState[s+1])
        );
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            outVal <= 1'b0;
        end else begin
            outVal <= stageVal[6];
        end
    end

    // qt holds the rotations as rows, Q wants them as columns
    always_ff @(posedge clk) begin
        rMatrix <= stageState[6].r;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                qMatrix.el[r][c] <= stageState[6].qt.el[c][r];
            end
        end
    end

endmodule

// ==== logic/qrPkg.sv ====
package qrPkg;

    // element format, signed, 16 of the 24 bits are fraction
    localparam int dataWidth = 24;
    localparam int fracBits  = 16;

    // lanes 0..3 carry the columns of R, lanes 4..7 the columns of Q transposed
    localparam int laneCount = 8;

    typedef logic signed [dataWidth-1:0] fixVal;

    localparam fixVal fixOne = fixVal'(1 << fracBits);  // 1.0

    typedef struct packed {
        fixVal [3:0][3:0] el;  // el[row][col]
    } matrix4;

    // everything a matrix carries between rotation stages
    typedef struct packed {
        matrix4 r;
        matrix4 qt;  // Q transposed, starts as identity
    } qrState;

    // one row pair spread over the lanes of a rotation
    typedef struct packed {
        fixVal [laneCount-1:0] x;  // row rowI
        fixVal [laneCount-1:0] y;  // row rowJ
        logic                  bypass;  // pivot y was already zero
    } rotLanes;

    // sense of one CORDIC micro-rotation
    typedef enum logic {
        rotDown,  // pivot y >= 0, turn clockwise
        rotUp     // pivot y < 0, turn counter-clockwise
    } rotDir;

endpackage

// ==== logic/rotationFinish.sv ====
`timescale 1ns/1ps

module rotationFinish #(
    parameter int cordicSteps = 16,
    parameter int pivotLane   = 0
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           inVal,
    input  qrPkg::rotLanes inLanes,
    output logic           outVal,
    output qrPkg::rotLanes outLanes
);
    import qrPkg::*;

    // 1 / prod(sqrt(1 + 2^-2k)), rounded to the element format
    function automatic fixVal calcInvGain(int steps);
        real gain;
        gain = 1.0;
        for (int k = 0; k < steps; k++) begin
            gain = gain / $sqrt(1.0 + 1.0 / (4.0 ** k));
        end
        return fixVal'($rtoi(gain * (2.0 ** fracBits) + 0.5));
    endfunction

    localparam fixVal invGain = calcInvGain(cordicSteps);

    function automatic fixVal scaleDown(fixVal v);
        logic signed [2*dataWidth-1:0] prod;
        prod = v * invGain;
        return fixVal'(prod >>> fracBits);  // drop the extra fraction bits
    endfunction

    rotLanes finished;

    always_comb begin
        finished = inLanes;
        if (!inLanes.bypass) begin
            for (int i = 0; i < laneCount; i++) begin
                finished.x[i] = scaleDown(inLanes.x[i]);
                finished.y[i] = scaleDown(inLanes.y[i]);
            end
        end
        // leftover CORDIC residue on the eliminated element is discarded
        finished.y[pivotLane] = '0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            outVal <= 1'b0;
        end else begin
            outVal <= inVal;
        end
    end

    always_ff @(posedge clk) begin
        outLanes <= finished;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the QR decomposition testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module qrDecompTb \
    -f files.f --Mdir obj_dir -o simv > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "SIMULATION PASSED" sim.log && echo "pass" && exit 0 ||
{ echo "fail, see sim.log"; exit 1; }

// ==== tb/qrDecompTb.sv ====
`timescale 1ns/1ps

module qrDecompTb;
    import qrPkg::*;

    localparam int numTests    = 10;
    localparam int wordsPerTest = 48;  // 16 input, 16 R, 16 Q
    localparam int latency     = 110;
    localparam int drainLimit  = 400;
    localparam int randTests   = 10;
    localparam int prodTol     = 1 << 11;  // about 0.03, rounding of six CORDIC rotations

    logic   clk = 1'b0;
    logic   reset;
    logic   inVal;
    matrix4 inMatrix;
    logic   outVal;
    matrix4 rMatrix;
    matrix4 qMatrix;

    fixVal vecMem [numTests*wordsPerTest];

    int     pendIdx[$];    // test index of every matrix in flight, -1 for a random one
    int     pendCycle[$];  // cycle count when it was driven
    matrix4 pendIn[$];     // input matrix of every matrix in flight
    int errorCount = 0;
    int sentCount  = 0;
    int recvCount  = 0;
    int cycleCount = 0;
    int seed;

    qrDecomp4 #(
        .cordicSteps (16)
    ) DUT (
        .clk      (clk),
        .reset    (reset),
        .inVal    (inVal),
        .inMatrix (inMatrix),
        .outVal   (outVal),
        .rMatrix  (rMatrix),
        .qMatrix  (qMatrix)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp, int tol);
        int diff;
        diff = int'(got - exp);
        if ($isunknown(got) || diff > tol || diff < -tol) begin
            errorCount++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic matrix4 fileInput(int idx);
        matrix4 m;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                m.el[r][c] = vecMem[idx*wordsPerTest + r*4 + c];
            end
        end
        return m;
    endfunction

    // elements in [-2, 2), well inside the input range
    function automatic matrix4 randomMatrix();
        matrix4 m;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                m.el[r][c] = fixVal'($signed(18'($random(seed))));
            end
        end
        return m;
    endfunction

    // element (i, j) of q times r, back in the element format
    function automatic int productElem(matrix4 q, matrix4 r, int i, int j);
        longint acc;
        acc = 0;
        for (int k = 0; k < 4; k++) begin
            acc += longint'($signed(q.el[i][k])) * longint'($signed(r.el[k][j]));
        end
        return int'(acc >>> fracBits);
    endfunction

    // one matrix strobe, called right after a falling edge
    task automatic driveMatrix(int idx, matrix4 m);
        inMatrix = m;
        inVal = 1'b1;
        pendIdx.push_back(idx);
        pendCycle.push_back(cycleCount);
        pendIn.push_back(m);
        sentCount++;
        @(negedge clk);
        inVal = 1'b0;
    endtask

    task automatic idleCycles(int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    // outputs are compared half a cycle after the rising edge
    always @(negedge clk) begin : monitorBlk
        int idx;
        int sentAt;
        int base;
        matrix4 inM;
        if (!reset && outVal) begin
            if (pendIdx.size() == 0) begin
                errorCount++;
                $display("result strobe seen with no matrix in flight");
            end else begin
                idx    = pendIdx.pop_front();
                sentAt = pendCycle.pop_front();
                inM    = pendIn.pop_front();
                base   = idx * wordsPerTest;
                recvCount++;
                checkValue("latency", cycleCount - sentAt, latency, 0);
                if (idx < 0) begin
                    // Q times R must give back the input
                    for (int r = 0; r < 4; r++) begin
                        for (int c = 0; c < 4; c++) begin
                            checkValue($sformatf("Q*R[%0d][%0d] random", r, c),
                                productElem(qMatrix, rMatrix, r, c),
                                $signed(inM.el[r][c]), prodTol);
                        end
                    end
                end else begin
                    for (int r = 0; r < 4; r++) begin
                        for (int c = 0; c < 4; c++) begin
                            checkValue($sformatf("rMatrix[%0d][%0d] test %0d", r, c, idx),
                                $signed(rMatrix.el[r][c]), vecMem[base + 16 + r*4 + c], 0);
                            checkValue($sformatf("qMatrix[%0d][%0d] test %0d", r, c, idx),
                                $signed(qMatrix.el[r][c]), vecMem[base + 32 + r*4 + c], 0);
                        end
                    end
                end
            end
        end
    end

    initial begin
        int gap;
        int waited;
        seed     = 32'hcd3a_9a22;
        reset    = 1'b1;
        inVal    = 1'b0;
        inMatrix = '0;
        $readmemh("tb/qrVectors.txt", vecMem);

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        idleCycles(3);

        // first pass with random idle gaps
        for (int t = 0; t < numTests; t++) begin
            driveMatrix(t, fileInput(t));
            gap = $unsigned($random(seed)) % 4;
            idleCycles(gap);
        end
        // second pass back-to-back
        for (int t = 0; t < numTests; t++) begin
            driveMatrix(t, fileInput(t));
        end
        // full matrices, every stage has to rotate
        for (int t = 0; t < randTests; t++) begin
            driveMatrix(-1, randomMatrix());
        end

        waited = 0;
        while (pendIdx.size() > 0 && waited < drainLimit) begin
            @(negedge clk);
            waited++;
        end
        if (pendIdx.size() > 0) begin
            errorCount++;
            $display("timeout: %0d results never came out", pendIdx.size());
        end

        idleCycles(20);  // catch any extra strobe
        checkValue("resultCount", recvCount, sentCount, 0);

        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/qrDecomp_checker.sv ====
`timescale 1ns/1ps

module qrDecomp_checker (
    input logic          clk,
    input logic          reset,
    input logic          inVal,
    input logic          outVal,
    input qrPkg::matrix4 rMatrix,
    input qrPkg::matrix4 qMatrix
);
    import qrPkg::*;

    localparam int latency = 110;

    // no result while reset holds
    assert property (@(posedge clk) reset |-> !outVal)
        else $error("outVal high during reset");

    assert property (@(posedge clk) disable iff (reset) outVal == $past(inVal, latency))
        else $error("outVal does not follow inVal by the pipeline latency");

    assert property (@(posedge clk) disable iff (reset)
        outVal |-> (rMatrix.el[1][0] == '0 && rMatrix.el[2][0] == '0
                 && rMatrix.el[3][0] == '0 && rMatrix.el[2][1] == '0
                 && rMatrix.el[3][1] == '0 && rMatrix.el[3][2] == '0))
        else $error("R has a nonzero element below the diagonal");

    assert property (@(posedge clk) disable iff (reset)
        outVal |-> !$isunknown({rMatrix, qMatrix}))
        else $error("unknown bits on a valid result");

endmodule

bind qrDecomp4 qrDecomp_checker uChecker (
    .clk     (clk),
    .reset   (reset),
    .inVal   (inVal),
    .outVal  (outVal),
    .rMatrix (rMatrix),
    .qMatrix (qMatrix)
);

// ==== tb/qrVectors.txt ====
// per test: 16 input elements, 16 expected R, 16 expected Q, row major
// 24-bit signed fixed point with 16 fraction bits
010000 000000 000000 000000 000000 010000 000000 000000 000000 000000 010000 000000 000000 000000 000000 010000 010000 000000 000000 000000 000000 010000 000000 000000 000000 000000 010000 000000 000000 000000 000000 010000 010000 000000 000000 000000 000000 010000 000000 000000 000000 000000 010000 000000 000000 000000 000000 010000
010000 008000 FF0000 020000 000000 020000 004000 FF8000 000000 000000 030000 010000 000000 000000 000000 00C000 010000 008000 FF0000 020000 000000 020000 004000 FF8000 000000 000000 030000 010000 000000 000000 000000 00C000 010000 000000 000000 000000 000000 010000 000000 000000 000000 000000 010000 000000 000000 000000 000000 010000
FF0000 000000 000000 000000 000000 020000 000000 000000 000000 000000 FD0000 000000 000000 000000 000000 040000 010000 000000 000000 000000 000000 020000 000000 000000 000000 000000 030000 000000 000000 000000 000000 040000 FF0000 000000 000000 000000 000000 010000 000000 000000 000000 000000 FF0000 000000 000000 000000 000000 010000
FE0000 010000 008000 FF0000 000000 018000 FF8000 004000 000000 000000 020000 010000 000000 000000 000000 FF0000 020000 FF0000 FF8000 010000 000000 018000 FF8000 004000 000000 000000 020000 010000 000000 000000 000000 010000 FF0000 000000 000000 000000 000000 010000 000000 000000 000000 000000 010000 000000 000000 000000 000000 FF0000
030000 020000 010000 008000 000000 FF0000 020000 FD0000 000000 000000 008000 004000 000000 000000 000000 020000 030000 020000 010000 008000 000000 010000 FE0000 030000 000000 000000 008000 004000 000000 000000 000000 FE0000 010000 000000 000000 000000 000000 FF0000 000000 000000 000000 000000 010000 000000 000000 000000 000000 FF0000
FF0000 FF0000 FF0000 FF0000 000000 FF0000 FF0000 FF0000 000000 000000 FF0000 FF0000 000000 000000 000000 FF0000 010000 010000 010000 010000 000000 010000 010000 010000 000000 000000 010000 010000 000000 000000 000000 010000 FF0000 000000 000000 000000 000000 FF0000 000000 000000 000000 000000 FF0000 000000 000000 000000 000000 FF0000
004000 03C000 FC4000 000000 000000 FC4000 000000 010000 000000 000000 010000 FF8000 000000 000000 000000 FD8000 004000 03C000 FC4000 000000 000000 03C000 000000 FF0000 000000 000000 010000 FF8000 000000 000000 000000 028000 010000 000000 000000 000000 000000 FF0000 000000 000000 000000 000000 010000 000000 000000 000000 000000 FF0000
000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 000000 010000 000000 000000 000000 000000 010000 000000 000000 000000 000000 010000 000000 000000 000000 000000 010000
FF8000 000000 000000 000000 000000 FF8000 000000 000000 000000 000000 FF8000 000000 000000 000000 000000 FF8000 008000 000000 000000 000000 000000 008000 000000 000000 000000 000000 008000 000000 000000 000000 000000 008000 FF0000 000000 000000 000000 000000 FF0000 000000 000000 000000 000000 FF0000 000000 000000 000000 000000 FF0000
018000 FE0000 000000 000000 000000 00C000 028000 000000 000000 000000 FE8000 030000 000000 000000 000000 008000 018000 FE0000 000000 000000 000000 00C000 028000 000000 000000 000000 018000 FD0000 000000 000000 000000 FF8000 010000 000000 000000 000000 000000 010000 000000 000000 000000 000000 FF0000 000000 000000 000000 000000 FF0000
